/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = convAcceleratorTb
FILELIST  = vlog.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = TB FAILED

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* bench/convAcceleratorTb.sv */
module convAcceleratorTb import convDataPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TAPS            = 3;
    localparam int IN_DEPTH        = 16;
    localparam int OUT_DEPTH       = 16;
    localparam int SEL_W           = $clog2(TAPS);
    localparam int CLK_PERIOD      = 40;
    localparam int RST_CYCLES      = 4;
    localparam int WAIT_LIMIT      = 200;                   // Longest single wait in cycles
    localparam int NUM_TESTS       = 6;
    localparam int MAX_SAMPLES     = OUT_DEPTH + 6;         // Longest stream, back-pressure test
    localparam int TEST_CYCLES     = 5 * MAX_SAMPLES + 40;  // Push, read and drain per test
    localparam int WATCHDOG_CYCLES = 2 * (RST_CYCLES + NUM_TESTS * TEST_CYCLES);

    logic             Clk = 1'b0;
    logic             rst;
    sampleT           sampleIn;
    logic             newline;
    logic             sampleWr;
    logic             inFull;
    logic             inEmpty;
    logic             coefWr;
    logic [SEL_W-1:0] coefSel;
    sampleT           coefIn;
    logic             cStart;
    logic             cBusy;
    logic             cReady;
    logic             resultRd;
    sampleT           resultOut;
    logic             outFull;
    logic             outEmpty;

    sampleT stimQ [$];                                      // Samples of the next run
    bit     lineQ [$];                                      // Newline tag per sample
    sampleT expQ  [$];                                      // Expected results in order
    sampleT coefModel [TAPS];                               // Coefficients as loaded
    int     readyCount = 0;                                 // cReady pulses seen so far
    int     errors     = 0;
    int     checks     = 0;
    int     testsRun   = 0;
    int     seed       = 32'h6b25;

    convAccelerator #(.TAPS(TAPS), .IN_DEPTH(IN_DEPTH), .OUT_DEPTH(OUT_DEPTH)) i_dut (
        .Clk(Clk), .rst(rst),
        .sampleIn(sampleIn), .newline(newline), .sampleWr(sampleWr),
        .inFull(inFull), .inEmpty(inEmpty),
        .coefWr(coefWr), .coefSel(coefSel), .coefIn(coefIn),
        .cStart(cStart), .cBusy(cBusy), .cReady(cReady),
        .resultRd(resultRd), .resultOut(resultOut), .outFull(outFull), .outEmpty(outEmpty)
    );

    always #(CLK_PERIOD / 2) Clk = ~Clk;

    always @(negedge Clk) begin
        if (!rst && cReady) begin
            readyCount++;                                   // Count completion pulses
        end
    end

    task automatic checkWord(input string name, input sampleT got, input sampleT exp);
        checks++;
        assert (got == exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expectTrue(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);                           // Plain words, no value pair
            errors++;
        end
    endtask

    task automatic loadCoef(input int idx, input sampleT value);
        coefModel[idx] = value;
        coefSel = SEL_W'(idx);
        coefIn  = value;
        coefWr  = 1'b1;
        @(negedge Clk);
        coefWr  = 1'b0;
    endtask

    task automatic pushSample(input sampleT value, input logic nl);
        int waited;
        waited = 0;
        while (inFull && waited < WAIT_LIMIT) begin
            @(negedge Clk);                                 // Device holds off on inFull
            waited++;
        end
        expectTrue(!inFull, "intake FIFO stayed full, sample not written");
        if (!inFull) begin
            sampleIn = value;
            newline  = nl;
            sampleWr = 1'b1;
            @(negedge Clk);
            sampleWr = 1'b0;
            newline  = 1'b0;
        end
    endtask

    task automatic pulseStart();
        cStart = 1'b1;
        @(negedge Clk);
        cStart = 1'b0;
    endtask

    task automatic addLine(input int len, input sampleT first, input sampleT step);
        for (int i = 0; i < len; i++) begin
            stimQ.push_back(first + sampleT'(i) * step);
            lineQ.push_back(i == 0);                        // Tag the first sample only
        end
    endtask

    task automatic addRandomLine(input int len);
        for (int i = 0; i < len; i++) begin
            stimQ.push_back(sampleT'($random(seed)) | 16'h8000); // Top bit set, large values
            lineQ.push_back(i == 0);
        end
    endtask

    // Convolution per line, coef k times the sample k places back, sum modulo 2^16
    function automatic void buildExpected();
        sampleT hist [$];
        longint acc;
        expQ.delete();
        foreach (stimQ[n]) begin
            if (lineQ[n]) begin
                hist.delete();                              // A new line forgets the window
            end
            hist.push_front(stimQ[n]);
            if (hist.size() > TAPS) begin
                void'(hist.pop_back());
            end
            if (hist.size() == TAPS) begin
                acc = 0;
                for (int k = 0; k < TAPS; k++) begin
                    acc += longint'(coefModel[k]) * longint'(hist[k]);
                end
                expQ.push_back(sampleT'(acc % 65536));
            end
        end
    endfunction

    task automatic runStream(input int preload);
        foreach (stimQ[n]) begin
            if (n == preload) begin
                checkBit("inFull", inFull, preload >= IN_DEPTH); // Nothing popped yet
                pulseStart();                               // Rest is written while running
            end
            pushSample(stimQ[n], lineQ[n]);
        end
        if (preload >= stimQ.size()) begin
            checkBit("inFull", inFull, stimQ.size() >= IN_DEPTH);
            pulseStart();
        end
    endtask

    task automatic collectResults();
        int waited;
        foreach (expQ[i]) begin
            waited = 0;
            while (outEmpty && waited < WAIT_LIMIT) begin
                @(negedge Clk);
                waited++;
            end
            expectTrue(!outEmpty, "timed out waiting for a result in the output FIFO");
            if (outEmpty) begin
                return;
            end
            resultRd = 1'b1;
            @(negedge Clk);                                 // resultOut valid after the read edge
            resultRd = 1'b0;
            checkWord("resultOut", resultOut, expQ[i]);
        end
    endtask

    task automatic expectReady(input int base);
        int waited;
        waited = 0;
        while (readyCount == base && waited < WAIT_LIMIT) begin
            @(negedge Clk);
            waited++;
        end
        expectTrue(readyCount > base, "cReady never pulsed after the run");
        repeat (4) @(negedge Clk);
        expectTrue(readyCount == base + 1, "cReady pulsed more than once for one run");
        checkBit("outEmpty", outEmpty, 1'b1);              // No extra or duplicated results
        checkBit("cBusy", cBusy, 1'b0);
    endtask

    task automatic runAndCheck(input int preload, input bit holdForFull);
        int base;
        int waited;
        buildExpected();
        base = readyCount;
        runStream(preload);
        if (holdForFull) begin
            waited = 0;
            while (!outFull && waited < WAIT_LIMIT) begin
                @(negedge Clk);                             // resultRd held low meanwhile
                waited++;
            end
            expectTrue(outFull, "output FIFO never filled while results were held back");
        end
        collectResults();
        expectReady(base);
        stimQ.delete();
        lineQ.delete();
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testsRun++;
        if (errors == errBefore) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s %0d errors", name, errors - errBefore);
        end
    endtask

    task automatic testReset();
        int e0;
        e0 = errors;
        checkBit("inEmpty", inEmpty, 1'b1);
        checkBit("outEmpty", outEmpty, 1'b1);
        checkBit("cBusy", cBusy, 1'b0);
        checkBit("cReady", cReady, 1'b0);
        reportTest("reset", e0);
    endtask

    task automatic testSingleLine();
        int e0;
        e0 = errors;
        loadCoef(0, 16'd1);
        loadCoef(1, 16'd2);
        loadCoef(2, 16'd3);
        addLine(6, 16'd10, 16'd7);                          // Four full windows
        runAndCheck(6, 1'b0);
        reportTest("singleLine", e0);
    endtask

    task automatic testLineRestart();
        int e0;
        e0 = errors;
        addLine(4, 16'd100, 16'd3);
        addLine(2, 16'd5, 16'd1);                           // Never fills a window
        runAndCheck(6, 1'b0);
        reportTest("lineRestart", e0);
    endtask

    task automatic testTruncation();
        int e0;
        e0 = errors;
        for (int k = 0; k < TAPS; k++) begin
            loadCoef(k, sampleT'($random(seed)) | 16'hc000);
        end
        addRandomLine(10);
        runAndCheck(10, 1'b0);
        reportTest("truncation", e0);
    endtask

    task automatic testBackPressure();
        int e0;
        e0 = errors;
        addLine(MAX_SAMPLES, 16'd1, 16'd9);                 // More results than OUT_DEPTH
        runAndCheck(IN_DEPTH, 1'b1);
        reportTest("backPressure", e0);
    endtask

    task automatic testCoefReload();
        int e0;
        e0 = errors;
        loadCoef(0, 16'd4);
        loadCoef(1, 16'd0);
        loadCoef(2, 16'hffff);
        addLine(6, 16'd20, 16'd11);
        runAndCheck(6, 1'b0);
        reportTest("coefReload", e0);
    endtask

    initial begin
        rst      = 1'b1;
        sampleIn = '0;
        newline  = 1'b0;
        sampleWr = 1'b0;
        coefWr   = 1'b0;
        coefSel  = '0;
        coefIn   = '0;
        cStart   = 1'b0;
        resultRd = 1'b0;
        for (int k = 0; k < TAPS; k++) begin
            coefModel[k] = '0;                              // DUT coefficients reset to zero
        end
        repeat (RST_CYCLES) @(negedge Clk);
        rst = 1'b0;
        @(negedge Clk);
        testReset();
        testSingleLine();
        testLineRestart();
        testTruncation();
        testBackPressure();
        testCoefReload();
        $display("summary %0d tests, %0d checks, %0d errors", testsRun, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Hang guard sized from the longest expected test
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* source/adderTree.sv */
module adderTree import convDataPkg::*; #(
    parameter int TAPS = 3                      // Number of products to add
) (
    input  logic                         Clk,
    input  logic                         rst,
    input  logic [TAPS-1:0][PROD_W-1:0]  products,  // Tap products from macArray
    input  logic                         prodValid, // Product set is a real result
    output logic                         resWr,     // Output FIFO write strobe
    output sampleT                       resData    // Truncated sum
);

    logic [PROD_W-1:0] sumFull;                 // Sum of all taps, wraps at PROD_W

    // Balanced in synthesis, written as a running sum
    always_comb begin
        sumFull = '0;
        for (int i = 0; i < TAPS; i++) begin
            sumFull = sumFull + products[i];
        end
    end

    // Low bits of the wrapped sum equal the true sum modulo 2^DATA_W
    always_ff @(posedge Clk) begin
        resData <= sumFull[DATA_W-1:0];         // Keep DATA_W low bits
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            resWr <= 1'b0;
        end else begin
            resWr <= prodValid;                 // One write per valid product set
        end
    end

endmodule

/* source/convAccelerator.sv */
module convAccelerator import convDataPkg::*, convCtrlPkg::*; #(
    parameter int TAPS      = 3,                // Window length
    parameter int IN_DEPTH  = 16,               // Intake FIFO entries
    parameter int OUT_DEPTH = 16,               // Output FIFO entries
    localparam int SEL_W    = (TAPS > 1) ? $clog2(TAPS) : 1
) (
    input  logic             Clk,
    input  logic             rst,
    input  sampleT           sampleIn,          // Sample from the external device
    input  logic             newline,           // First sample of a line
    input  logic             sampleWr,          // Sample write strobe
    output logic             inFull,            // Device must stop writing
    output logic             inEmpty,
    input  logic             coefWr,            // Coefficient write strobe
    input  logic [SEL_W-1:0] coefSel,           // Coefficient index
    input  sampleT           coefIn,            // Coefficient value
    input  logic             cStart,            // Start pulse
    output logic             cBusy,             // Accelerator running
    output logic             cReady,            // Completion pulse
    input  logic             resultRd,          // Result read strobe
    output sampleT           resultOut,         // Result, valid after the read edge
    output logic             outFull,
    output logic             outEmpty
);

    taggedSampleT                inWord;        // Sample tagged with its line start
    taggedSampleT                popData;       // Intake FIFO read data
    logic                        pop;
    logic                        shiftEn;
    logic                        outLowSpace;
    logic [TAPS-1:0][PROD_W-1:0] products;
    logic                        prodValid;
    logic                        resWr;
    sampleT                      resData;

    assign inWord = '{lineStart: newline, sample: sampleIn};

    syncFifo #(.payloadT(taggedSampleT), .DEPTH(IN_DEPTH), .MARGIN(1)) intakeFifo (
        .Clk(Clk), .rst(rst),
        .wrEn(sampleWr), .wrData(inWord), .full(inFull),
        .rdEn(pop), .rdData(popData), .empty(inEmpty),
        .lowSpace()                             // Device uses inFull only
    );

    // Margin covers the pipeline, the result register and the pop decided this cycle
    syncFifo #(.payloadT(sampleT), .DEPTH(OUT_DEPTH), .MARGIN(PIPE_DEPTH + 2)) outFifo (
        .Clk(Clk), .rst(rst),
        .wrEn(resWr), .wrData(resData), .full(outFull),
        .rdEn(resultRd), .rdData(resultOut), .empty(outEmpty),
        .lowSpace(outLowSpace)
    );

    convController controller (
        .Clk(Clk), .rst(rst), .cStart(cStart),
        .inEmpty(inEmpty), .outLowSpace(outLowSpace),
        .pop(pop), .shiftEn(shiftEn), .cBusy(cBusy), .cReady(cReady)
    );

    macArray #(.TAPS(TAPS), .SEL_W(SEL_W)) macArr (
        .Clk(Clk), .rst(rst),
        .coefWr(coefWr), .coefSel(coefSel), .coefIn(coefIn), .cBusy(cBusy),
        .shiftEn(shiftEn), .popData(popData),
        .products(products), .prodValid(prodValid)
    );

    adderTree #(.TAPS(TAPS)) adder (
        .Clk(Clk), .rst(rst),
        .products(products), .prodValid(prodValid),
        .resWr(resWr), .resData(resData)
    );

endmodule

/* source/convController.sv */
module convController import convCtrlPkg::*; (
    input  logic Clk,
    input  logic rst,
    input  logic cStart,                        // Start pulse, honoured in IDLE only
    input  logic inEmpty,                       // Intake FIFO empty
    input  logic outLowSpace,                   // Output FIFO cannot absorb a full pipeline
    output logic pop,                           // Intake FIFO read strobe
    output logic shiftEn,                       // Window shift, one cycle after a pop
    output logic cBusy,                         // High outside IDLE
    output logic cReady                         // One cycle pulse on completion
);

    ctrlStateT             state;
    ctrlStateT             nextState;
    logic [PIPE_DEPTH-1:0] inFlight;            // One bit per pop still in the pipeline
    logic                  drained;             // Nothing left between pop and write
    logic                  finish;              // DRAIN exit to IDLE this cycle

    assign drained = (inFlight == '0);
    assign finish  = (state == DRAIN) && inEmpty && drained;

    // Pops only in RUN, and only with room downstream
    assign pop = (state == RUN) && !inEmpty && !outLowSpace;

    // Popped word reaches the macArray input one edge later
    assign shiftEn = inFlight[0];

    assign cBusy = (state != IDLE);             // Rises the cycle after cStart

    // Next state
    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (cStart) begin
                    nextState = RUN;
                end
            end
            RUN: begin
                if (inEmpty) begin
                    nextState = DRAIN;          // Wait for the pipeline to empty
                end
            end
            DRAIN: begin
                if (!inEmpty) begin
                    nextState = RUN;            // Late samples resume popping
                end else if (drained) begin
                    nextState = IDLE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            state    <= IDLE;
            inFlight <= '0;
            cReady   <= 1'b0;
        end else begin
            state    <= nextState;
            inFlight <= {inFlight[PIPE_DEPTH-2:0], pop}; // Bit leaves as the result is written
            cReady   <= finish;                 // Single pulse, state is IDLE by then
        end
    end

    // Completion is never flagged while work is still being taken in
    readyNotWithPop: assert property (@(posedge Clk) disable iff (rst) !(cReady && pop))
        else $error("convController cReady together with pop");

endmodule

/* source/convCtrlPkg.sv */
package convCtrlPkg;

    // Controller states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,                           // Waiting for cStart
        RUN   = 2'd1,                           // Popping samples
        DRAIN = 2'd2                            // Intake empty, waiting on in-flight items
    } ctrlStateT;

    // Cycles from a pop edge to the result write edge
    // Pop at t, window shift at t+1, products at t+2, sum and write at t+3
    parameter int PIPE_DEPTH = 3;

endpackage

/* source/convDataPkg.sv */
package convDataPkg;

    // Word widths shared by the whole datapath
    parameter int DATA_W = 16;                  // Sample, coefficient and result width
    parameter int PROD_W = 2 * DATA_W;          // Full width of one tap product

    // One unsigned sample word
    typedef logic [DATA_W-1:0] sampleT;         // Also the result word in the output FIFO

    // Intake FIFO payload
    typedef struct packed {
        logic   lineStart;                      // High on the first sample of a line
        sampleT sample;                         // Sample value
    } taggedSampleT;

    // Layout of taggedSampleT is {lineStart, sample}
    // MSB is the tag so a 17 bit dump reads as tag then value

endpackage

/* source/macArray.sv */
module macArray import convDataPkg::*; #(
    parameter int TAPS  = 3,                    // Window length and coefficient count
    parameter int SEL_W = 2                     // Coefficient select width
) (
    input  logic                         Clk,
    input  logic                         rst,
    input  logic                         coefWr,    // Coefficient write strobe
    input  logic [SEL_W-1:0]             coefSel,   // Coefficient index
    input  sampleT                       coefIn,    // Coefficient value
    input  logic                         cBusy,     // Controller busy
    input  logic                         shiftEn,   // Shift popData into the window
    input  taggedSampleT                 popData,   // Intake FIFO read data
    output logic [TAPS-1:0][PROD_W-1:0]  products,  // Registered tap products
    output logic                         prodValid  // Products come from a full window
);

    localparam int FILL_W = $clog2(TAPS + 1);

    sampleT            coef [TAPS];             // Coefficient registers
    sampleT            win  [TAPS];             // win[0] is the newest sample
    logic [FILL_W-1:0] fillCnt;                 // Samples of the current line in the window
    logic              shiftD;                  // Shift happened last edge

    // Coefficients, written only while idle
    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < TAPS; i++) begin
                coef[i] <= '0;
            end
        end else if (coefWr && !cBusy && int'(coefSel) < TAPS) begin
            coef[coefSel] <= coefIn;            // Out of range selects are ignored
        end
    end

    // Sample window and line fill tracking
    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < TAPS; i++) begin
                win[i] <= '0;
            end
            fillCnt <= '0;
            shiftD  <= 1'b0;
        end else begin
            shiftD <= shiftEn;
            if (shiftEn) begin
                win[0] <= popData.sample;
                for (int i = 1; i < TAPS; i++) begin
                    win[i] <= win[i-1];         // Older samples move up one slot
                end
                if (popData.lineStart) begin
                    fillCnt <= FILL_W'(1);      // New line restarts the count
                end else if (fillCnt != FILL_W'(TAPS)) begin
                    fillCnt <= fillCnt + 1'b1;  // Saturates at TAPS
                end
            end
        end
    end

    // Product stage
    always_ff @(posedge Clk) begin
        for (int i = 0; i < TAPS; i++) begin
            products[i] <= PROD_W'(coef[i]) * PROD_W'(win[i]); // coef i times sample n-i
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            prodValid <= 1'b0;
        end else begin
            prodValid <= shiftD && (fillCnt == FILL_W'(TAPS)); // Full window of this line only
        end
    end

    coefOnlyWhenIdle: assert property (@(posedge Clk) disable iff (rst) !(coefWr && cBusy))
        else $error("macArray coefficient write while busy");

endmodule

/* source/syncFifo.sv */
module syncFifo #(
    parameter type payloadT = logic [15:0],     // Word type stored in the buffer
    parameter int  DEPTH    = 16,               // Number of entries
    parameter int  MARGIN   = 1                 // lowSpace threshold in free entries
) (
    input  logic    Clk,
    input  logic    rst,
    input  logic    wrEn,                       // Write strobe
    input  payloadT wrData,                     // Write data
    output logic    full,                       // No free entries
    input  logic    rdEn,                       // Read strobe
    output payloadT rdData,                     // Registered read data
    output logic    empty,                      // No stored entries
    output logic    lowSpace                    // Fewer than MARGIN free entries
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payloadT          mem [DEPTH];              // Storage array
    logic [PTR_W-1:0] wrPtr;                    // Next slot to write
    logic [PTR_W-1:0] rdPtr;                    // Next slot to read
    logic [CNT_W-1:0] count;                    // Occupancy
    logic             doWr;
    logic             doRd;

    assign doWr = wrEn && !full;                // Writes into a full buffer are dropped
    assign doRd = rdEn && !empty;               // Reads of an empty buffer are ignored

    // Pointers and occupancy
    always_ff @(posedge Clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWr) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1; // Wrap at DEPTH
            end
            if (doRd) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doWr, doRd})
                2'b10:   count <= count + 1'b1; // Write only
                2'b01:   count <= count - 1'b1; // Read only
                default: count <= count;        // Both or neither
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (doWr) begin
            mem[wrPtr] <= wrData;
        end
        if (doRd) begin
            rdData <= mem[rdPtr];               // Holds until the next read
        end
    end

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign lowSpace = (DEPTH - int'(count)) < MARGIN; // Free entries below margin

    noWriteWhenFull: assert property (@(posedge Clk) disable iff (rst) !(wrEn && full))
        else $error("syncFifo write while full, word dropped");
    noReadWhenEmpty: assert property (@(posedge Clk) disable iff (rst) !(rdEn && empty))
        else $error("syncFifo read while empty");

endmodule

/* vlog.f */
source/convDataPkg.sv
source/convCtrlPkg.sv
source/syncFifo.sv
source/convController.sv
source/macArray.sv
source/adderTree.sv
source/convAccelerator.sv
bench/convAcceleratorTb.sv
